// File: cl_miner_shell.f
logic/ocl_axil_pkg.sv
logic/miner_regs_pkg.sv
logic/ocl_axil_slave.sv
logic/miner_ctrl_regs.sv
logic/hello_vled_regs.sv
logic/cl_miner_shell.sv
verification/cl_miner_shell_tb.sv

// File: logic/cl_miner_shell.sv
// Top level of the miner register front end; connects the OCL slave to both register blocks
`timescale 1ns/1ps

module cl_miner_shell
  import ocl_axil_pkg::*;
  import miner_regs_pkg::*;
#(
  parameter int BLK_CNT = 8
)
(
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,
  input  axil_m2s_t                  ocl_m2s,
  output axil_s2m_t                  ocl_s2m,
  input  logic [15:0]                sh_cl_status_vdip,
  output logic [15:0]                cl_sh_status_vled,
  output miner_cmd_t                 miner_cmd,
  output logic [31:0]                nonce_size,
  output logic [$clog2(BLK_CNT)-1:0] hash_select,
  output logic                       hash_re,
  input  miner_status_t              miner_status,
  input  logic [31:0]                nonce,
  input  logic [31:0]                heavyhash
);

  // Internal register bus
  reg_wr_t     reg_wr;
  reg_rd_req_t reg_rd_req;
  reg_rd_rsp_t rd_rsp_hello;
  reg_rd_rsp_t rd_rsp_miner;

  // ------------------------------------------------------------
  // Host port
  // ------------------------------------------------------------
  ocl_axil_slave u_ocl_axil_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ocl_m2s         (ocl_m2s),
    .ocl_s2m         (ocl_s2m),
    .reg_wr          (reg_wr),
    .reg_rd_req      (reg_rd_req),
    .rd_rsp_hello    (rd_rsp_hello),
    .rd_rsp_miner    (rd_rsp_miner)
  );

  // ------------------------------------------------------------
  // Register blocks
  // ------------------------------------------------------------
  hello_vled_regs u_hello_vled_regs (
    .clk_main_a0       (clk_main_a0),
    .rst_main_n_sync   (rst_main_n_sync),
    .reg_wr            (reg_wr),
    .reg_rd_req        (reg_rd_req),
    .rd_rsp            (rd_rsp_hello),
    .sh_cl_status_vdip (sh_cl_status_vdip),
    .cl_sh_status_vled (cl_sh_status_vled)
  );

  // Lane count sizes hash_select
  miner_ctrl_regs #(
    .BLK_CNT (BLK_CNT)
  ) u_miner_ctrl_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr          (reg_wr),
    .reg_rd_req      (reg_rd_req),
    .rd_rsp          (rd_rsp_miner),
    .miner_cmd       (miner_cmd),
    .nonce_size      (nonce_size),
    .hash_select     (hash_select),
    .hash_re         (hash_re),
    .miner_status    (miner_status),
    .nonce           (nonce),
    .heavyhash       (heavyhash)
  );

endmodule

// File: logic/hello_vled_regs.sv
// Scratch register with byte-swapped readback and the DIP-masked virtual LED output
`timescale 1ns/1ps

module hello_vled_regs
  import miner_regs_pkg::*;
(
  input  logic        clk_main_a0,
  input  logic        rst_main_n_sync,
  input  reg_wr_t     reg_wr,
  input  reg_rd_req_t reg_rd_req,
  output reg_rd_rsp_t rd_rsp,
  input  logic [15:0] sh_cl_status_vdip,
  output logic [15:0] cl_sh_status_vled
);

  logic [31:0] scratch_q;
  logic [31:0] scratch_swapped;
  logic [15:0] vled_q;
  // DIP synchronizer stages
  logic [15:0] vdip_q1;
  logic [15:0] vdip_q2;

  // ------------------------------------------------------------
  // Scratch and LED shadow
  // ------------------------------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      scratch_q         <= 32'h0;
      vled_q            <= 16'h0;
      vdip_q1           <= 16'h0;
      vdip_q2           <= 16'h0;
      cl_sh_status_vled <= 16'h0;
    end
    else
    begin
      if (reg_wr.valid && (reg_wr.addr == HELLO_WORLD_ADDR))
        scratch_q <= reg_wr.data;
      // LED follows low half of scratch, one cycle behind
      vled_q <= scratch_q[15:0];
      // Switches come from another domain
      vdip_q1 <= sh_cl_status_vdip;
      vdip_q2 <= vdip_q1;
      // Switch off = LED dark
      cl_sh_status_vled <= vled_q & vdip_q2;
    end
  end

  // Byte 0 ends up in the top byte
  assign scratch_swapped = {scratch_q[7:0], scratch_q[15:8],
                            scratch_q[23:16], scratch_q[31:24]};

  // ------------------------------------------------------------
  // Readback
  // ------------------------------------------------------------
  always_comb
  begin
    rd_rsp.hit  = 1'b0;
    rd_rsp.data = 32'h0;
    if (reg_rd_req.valid && (reg_rd_req.addr == HELLO_WORLD_ADDR))
    begin
      rd_rsp.hit  = 1'b1;
      rd_rsp.data = scratch_swapped;
    end
    else if (reg_rd_req.valid && (reg_rd_req.addr == VLED_ADDR))
    begin
      // Unmasked LED value
      rd_rsp.hit  = 1'b1;
      rd_rsp.data = {16'h0, vled_q};
    end
  end

endmodule

// File: logic/miner_ctrl_regs.sv
// Miner control block that decodes host writes into core commands and returns core results
`timescale 1ns/1ps

module miner_ctrl_regs
  import miner_regs_pkg::*;
#(
  parameter int BLK_CNT = 8
)
(
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,
  input  reg_wr_t                    reg_wr,
  input  reg_rd_req_t                reg_rd_req,
  output reg_rd_rsp_t                rd_rsp,
  output miner_cmd_t                 miner_cmd,
  output logic [31:0]                nonce_size,
  output logic [$clog2(BLK_CNT)-1:0] hash_select,
  output logic                       hash_re,
  input  miner_status_t              miner_status,
  input  logic [31:0]                nonce,
  input  logic [31:0]                heavyhash
);

  localparam int HSEL_W = $clog2(BLK_CNT);

  // Write decode
  logic wr_bh;
  logic wr_mx;
  logic wr_tg;
  logic wr_start;
  logic wr_stop;
  logic wr_cmd;

  // Registered command pulses and their word
  logic        bh_we_q;
  logic        mx_we_q;
  logic        tg_we_q;
  logic        start_q;
  logic        stop_q;
  logic [31:0] word_q;

  assign wr_bh    = reg_wr.valid && (reg_wr.addr == BLOCK_HEADER_ADDR);
  assign wr_mx    = reg_wr.valid && (reg_wr.addr == MATRIX_ADDR);
  assign wr_tg    = reg_wr.valid && (reg_wr.addr == TARGET_ADDR);
  assign wr_start = reg_wr.valid && (reg_wr.addr == START_ADDR);
  assign wr_stop  = reg_wr.valid && (reg_wr.addr == STOP_ADDR);
  assign wr_cmd   = wr_bh || wr_mx || wr_tg || wr_start || wr_stop;

  // ------------------------------------------------------------
  // Command pulses and held settings
  // ------------------------------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      bh_we_q     <= 1'b0;
      mx_we_q     <= 1'b0;
      tg_we_q     <= 1'b0;
      start_q     <= 1'b0;
      stop_q      <= 1'b0;
      nonce_size  <= 32'h0;
      hash_select <= '0;
      hash_re     <= 1'b0;
    end
    else
    begin
      // One write per cycle, so pulses stay exclusive
      bh_we_q <= wr_bh;
      mx_we_q <= wr_mx;
      tg_we_q <= wr_tg;
      start_q <= wr_start;
      stop_q  <= wr_stop;

      if (reg_wr.valid && (reg_wr.addr == NONCE_SIZE_ADDR))
        nonce_size <= reg_wr.data;
      // Only enough bits to index a lane
      if (reg_wr.valid && (reg_wr.addr == HASH_SEL_ADDR))
        hash_select <= reg_wr.data[HSEL_W-1:0];

      // Lines up with the first rvalid cycle of the slave
      hash_re <= reg_rd_req.valid && (reg_rd_req.addr == HEAVYHASH_ADDR);
    end
  end

  // Word shared by all commands
  always_ff @(posedge clk_main_a0)
  begin
    if (wr_cmd)
      word_q <= reg_wr.data;
  end

  always_comb
  begin
    miner_cmd.block_header_we = bh_we_q;
    miner_cmd.matrix_we       = mx_we_q;
    miner_cmd.target_we       = tg_we_q;
    miner_cmd.start           = start_q;
    miner_cmd.stop            = stop_q;
    miner_cmd.word            = word_q;
  end

  // ------------------------------------------------------------
  // Result readback
  // ------------------------------------------------------------
  always_comb
  begin
    rd_rsp.hit  = 1'b0;
    rd_rsp.data = 32'h0;
    if (reg_rd_req.valid)
    begin
      case (reg_rd_req.addr)
        STATUS_ADDR:
        begin
          rd_rsp.hit  = 1'b1;
          rd_rsp.data = {30'h0, miner_status};
        end
        NONCE_ADDR:
        begin
          rd_rsp.hit  = 1'b1;
          rd_rsp.data = nonce;
        end
        HEAVYHASH_ADDR:
        begin
          rd_rsp.hit  = 1'b1;
          rd_rsp.data = heavyhash;
        end
        default:
        begin
          rd_rsp.hit  = 1'b0;
          rd_rsp.data = 32'h0;
        end
      endcase
    end
  end

  // Core sees at most one command per cycle
  a_cmd_onehot: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    $onehot0({bh_we_q, mx_we_q, tg_we_q, start_q, stop_q})
  ) else $error("more than one miner command pulse");

endmodule

// File: logic/miner_regs_pkg.sv
// Register map and register-access types shared by the AXI slave and the register blocks
package miner_regs_pkg;

  // ------------------------------------------------------------
  // Address map, byte addresses on the OCL BAR
  // ------------------------------------------------------------
  // Scratch and LED block
  localparam logic [31:0] HELLO_WORLD_ADDR  = 32'h0000_0500;
  localparam logic [31:0] VLED_ADDR         = 32'h0000_0504;

  // Miner command registers, write side
  localparam logic [31:0] BLOCK_HEADER_ADDR = 32'h0000_0510;
  localparam logic [31:0] MATRIX_ADDR       = 32'h0000_0514;
  localparam logic [31:0] TARGET_ADDR       = 32'h0000_0518;
  localparam logic [31:0] NONCE_SIZE_ADDR   = 32'h0000_051C;
  localparam logic [31:0] START_ADDR        = 32'h0000_0520;
  localparam logic [31:0] STOP_ADDR         = 32'h0000_0524;
  localparam logic [31:0] HASH_SEL_ADDR     = 32'h0000_0528;

  // Miner result registers, read side
  localparam logic [31:0] STATUS_ADDR       = 32'h0000_0530;
  localparam logic [31:0] NONCE_ADDR        = 32'h0000_0534;
  localparam logic [31:0] HEAVYHASH_ADDR    = 32'h0000_0538;

  // Read data for an address nobody claims
  localparam logic [31:0] UNIMPLEMENTED_VALUE = 32'hDEAD_BEEF;

  // ------------------------------------------------------------
  // Internal register bus
  // ------------------------------------------------------------
  // Full-word write, valid for one cycle
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] data;
  } reg_wr_t;

  // Read request, valid for one cycle
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } reg_rd_req_t;

  // Combinational answer in the request cycle
  typedef struct packed {
    logic        hit;
    logic [31:0] data;
  } reg_rd_rsp_t;

  // ------------------------------------------------------------
  // Miner core side
  // ------------------------------------------------------------
  // One-hot pulses, word shared by all of them
  typedef struct packed {
    logic        block_header_we;
    logic        matrix_we;
    logic        target_we;
    logic        start;
    logic        stop;
    logic [31:0] word;
  } miner_cmd_t;

  typedef logic [1:0] miner_status_t;

endpackage

// File: logic/ocl_axil_pkg.sv
// AXI4-Lite host port types for the OCL register interface, imported by the slave and top level
package ocl_axil_pkg;

  // ------------------------------------------------------------
  // Host to custom logic
  // ------------------------------------------------------------
  // Single-beat access only, so no len, size or burst fields
  typedef struct packed {
    logic        awvalid;
    logic [31:0] awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic        bready;
    logic        arvalid;
    logic [31:0] araddr;
    logic        rready;
  } axil_m2s_t;

  // ------------------------------------------------------------
  // Custom logic to host
  // ------------------------------------------------------------
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_s2m_t;

  // Only response ever returned
  localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

endpackage

// File: logic/ocl_axil_slave.sv
// AXI4-Lite single-beat slave that turns host transfers into internal register reads and writes
`timescale 1ns/1ps

module ocl_axil_slave
  import ocl_axil_pkg::*;
  import miner_regs_pkg::*;
(
  input  logic        clk_main_a0,
  input  logic        rst_main_n_sync,
  input  axil_m2s_t   ocl_m2s,
  output axil_s2m_t   ocl_s2m,
  output reg_wr_t     reg_wr,
  output reg_rd_req_t reg_rd_req,
  input  reg_rd_rsp_t rd_rsp_hello,
  input  reg_rd_rsp_t rd_rsp_miner
);

  // Write channel state
  logic        wr_active;
  logic [31:0] wr_addr;
  logic        bvalid_q;
  logic        awready;
  logic        wready;

  // Read channel state
  logic        rd_pend;
  logic [31:0] rd_addr;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic        arready;
  logic [31:0] rd_data_sel;

  // Handshake events
  logic        aw_fire;
  logic        w_fire;
  logic        b_fire;
  logic        ar_fire;
  logic        r_fire;

  // ------------------------------------------------------------
  // Write path
  // ------------------------------------------------------------
  // Busy from AW accept until the B handshake
  assign awready = !wr_active && !bvalid_q;
  // W only completes while an address is held
  assign wready  = wr_active && ocl_m2s.wvalid;

  assign aw_fire = ocl_m2s.awvalid && awready;
  assign w_fire  = wready;
  assign b_fire  = bvalid_q && ocl_m2s.bready;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      wr_active <= 1'b0;
      bvalid_q  <= 1'b0;
    end
    else
    begin
      // AW and W never fire together
      if (aw_fire)
        wr_active <= 1'b1;
      else if (w_fire)
        wr_active <= 1'b0;

      // Response held until the host takes it
      if (w_fire)
        bvalid_q <= 1'b1;
      else if (b_fire)
        bvalid_q <= 1'b0;
    end
  end

  // Address latch
  always_ff @(posedge clk_main_a0)
  begin
    if (aw_fire)
      wr_addr <= ocl_m2s.awaddr;
  end

  // Broadcast write, same cycle as W transfer
  assign reg_wr.valid = w_fire;
  assign reg_wr.addr  = wr_addr;
  assign reg_wr.data  = ocl_m2s.wdata;

  // ------------------------------------------------------------
  // Read path
  // ------------------------------------------------------------
  assign arready = !rd_pend && !rvalid_q;
  assign ar_fire = ocl_m2s.arvalid && arready;
  assign r_fire  = rvalid_q && ocl_m2s.rready;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      rd_pend  <= 1'b0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      // Request strobe lasts one cycle
      rd_pend <= ar_fire;
      if (rd_pend)
        rvalid_q <= 1'b1;
      else if (r_fire)
        rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (ar_fire)
      rd_addr <= ocl_m2s.araddr;
    // Captured once, held through back-pressure
    if (rd_pend)
      rdata_q <= rd_data_sel;
  end

  assign reg_rd_req.valid = rd_pend;
  assign reg_rd_req.addr  = rd_addr;

  // Pick the block that claims the address
  always_comb
  begin
    if (rd_rsp_hello.hit)
      rd_data_sel = rd_rsp_hello.data;
    else if (rd_rsp_miner.hit)
      rd_data_sel = rd_rsp_miner.data;
    else
      rd_data_sel = UNIMPLEMENTED_VALUE;
  end

  // ------------------------------------------------------------
  // Host outputs
  // ------------------------------------------------------------
  always_comb
  begin
    ocl_s2m.awready = awready;
    ocl_s2m.wready  = wready;
    ocl_s2m.bvalid  = bvalid_q;
    ocl_s2m.bresp   = AXIL_RESP_OKAY;
    ocl_s2m.arready = arready;
    ocl_s2m.rvalid  = rvalid_q;
    ocl_s2m.rdata   = rdata_q;
    ocl_s2m.rresp   = AXIL_RESP_OKAY;
  end

  // Read data must not move under a stalled R channel
  a_rdata_stable: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (rvalid_q && !ocl_m2s.rready) |=> $stable(rdata_q)
  ) else $error("rdata changed while R channel stalled");

  // Address maps of the two blocks are disjoint
  a_single_hit: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !(rd_rsp_hello.hit && rd_rsp_miner.hit)
  ) else $error("two register blocks claimed one read");

endmodule

// File: run_sim.sh
#!/bin/bash
# Compile the miner register front end with its testbench and run it under Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module cl_miner_shell_tb \
  --Mdir obj_dir \
  -f cl_miner_shell.f

sim_out=$(./obj_dir/Vcl_miner_shell_tb 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST OK"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: verification/cl_miner_shell_tb.sv
// Top-level testbench run by Verilator; random AXI4-Lite traffic checked against a register model
`timescale 1ns/1ps

module cl_miner_shell_tb
  import ocl_axil_pkg::*;
  import miner_regs_pkg::*;
();

  localparam int BLK_CNT = 8;
  localparam int TIMEOUT = 50;
  localparam int N_OPS   = 400;

  // DUT connections
  logic          clk_main_a0 = 1'b0;
  logic          rst_main_n_sync;
  axil_m2s_t     ocl_m2s;
  axil_s2m_t     ocl_s2m;
  logic [15:0]   sh_cl_status_vdip;
  logic [15:0]   cl_sh_status_vled;
  miner_cmd_t    miner_cmd;
  logic [31:0]   nonce_size;
  logic [2:0]    hash_select;
  logic          hash_re;
  miner_status_t miner_status;
  logic [31:0]   nonce;
  logic [31:0]   heavyhash;

  // Register model
  logic [31:0] m_scratch;
  logic [31:0] m_nonce_size;
  logic [2:0]  m_hash_select;
  int          exp_pulses;
  int          exp_hash_reads;
  int          exp_bresp;

  // Monitor counts
  int          seen_pulses;
  int          seen_hash_re;
  int          seen_bresp;
  logic [4:0]  mon_pulses;

  // Map addresses plus two holes
  logic [31:0] addr_table [14] = '{
    HELLO_WORLD_ADDR, VLED_ADDR, BLOCK_HEADER_ADDR, MATRIX_ADDR,
    TARGET_ADDR, NONCE_SIZE_ADDR, START_ADDR, STOP_ADDR,
    HASH_SEL_ADDR, STATUS_ADDR, NONCE_ADDR, HEAVYHASH_ADDR,
    32'h0000_050C, 32'h0000_053C
  };

  always #4 clk_main_a0 = ~clk_main_a0;

  cl_miner_shell #(
    .BLK_CNT (BLK_CNT)
  ) UUT (
    .clk_main_a0       (clk_main_a0),
    .rst_main_n_sync   (rst_main_n_sync),
    .ocl_m2s           (ocl_m2s),
    .ocl_s2m           (ocl_s2m),
    .sh_cl_status_vdip (sh_cl_status_vdip),
    .cl_sh_status_vled (cl_sh_status_vled),
    .miner_cmd         (miner_cmd),
    .nonce_size        (nonce_size),
    .hash_select       (hash_select),
    .hash_re           (hash_re),
    .miner_status      (miner_status),
    .nonce             (nonce),
    .heavyhash         (heavyhash)
  );

  assign mon_pulses = {miner_cmd.block_header_we, miner_cmd.matrix_we,
                       miner_cmd.target_we, miner_cmd.start, miner_cmd.stop};

  // ------------------------------------------------------------
  // Error handling and timing helpers
  // ------------------------------------------------------------
  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp)
    begin
      $display("Fail at %0t ns: %s expected %h actual %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic timeout_error(input string what);
    $display("Timeout: %s did not arrive within %0d cycles", what, TIMEOUT);
    stop_run();
  endtask

  // Drive point just after the rising edge
  task automatic step();
    @(posedge clk_main_a0);
    #1;
  endtask

  // Sample point in mid cycle
  task automatic sample();
    @(negedge clk_main_a0);
  endtask

  // ------------------------------------------------------------
  // Model rules
  // ------------------------------------------------------------
  function automatic logic [4:0] expected_cmd(input logic [31:0] addr);
    case (addr)
      BLOCK_HEADER_ADDR: return 5'b10000;
      MATRIX_ADDR:       return 5'b01000;
      TARGET_ADDR:       return 5'b00100;
      START_ADDR:        return 5'b00010;
      STOP_ADDR:         return 5'b00001;
      default:           return 5'b00000;
    endcase
  endfunction

  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    logic [31:0] r;
    r = UNIMPLEMENTED_VALUE;
    case (addr)
      HELLO_WORLD_ADDR:
      begin
        // Byte i comes from byte 3-i
        for (int i = 0; i < 4; i++)
          r[8*i +: 8] = m_scratch[8*(3-i) +: 8];
      end
      VLED_ADDR:      r = {16'h0, m_scratch[15:0]};
      STATUS_ADDR:    r = {30'h0, miner_status};
      NONCE_ADDR:     r = nonce;
      HEAVYHASH_ADDR: r = heavyhash;
      default:        r = UNIMPLEMENTED_VALUE;
    endcase
    return r;
  endfunction

  // ------------------------------------------------------------
  // Monitor
  // ------------------------------------------------------------
  always @(negedge clk_main_a0)
  begin
    if (rst_main_n_sync)
    begin
      if ($countones(mon_pulses) > 1)
      begin
        $display("Two miner command pulses high together at %0t ns", $time);
        stop_run();
      end
      seen_pulses += $countones(mon_pulses);
      if (hash_re)
        seen_hash_re++;
      // B handshake completes on the coming edge
      if (ocl_s2m.bvalid && ocl_m2s.bready)
        seen_bresp++;
    end
  end

  // ------------------------------------------------------------
  // Bus tasks
  // ------------------------------------------------------------
  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
    int n;
    int delay;
    step();
    ocl_m2s.awvalid = 1'b1;
    ocl_m2s.awaddr  = addr;
    sample();
    n = 0;
    while (!ocl_s2m.awready)
    begin
      n++;
      if (n > TIMEOUT)
        timeout_error("awready");
      sample();
    end
    step();
    ocl_m2s.awvalid = 1'b0;
    ocl_m2s.wvalid  = 1'b1;
    ocl_m2s.wdata   = data;
    sample();
    n = 0;
    while (!ocl_s2m.wready)
    begin
      n++;
      if (n > TIMEOUT)
        timeout_error("wready");
      sample();
    end
    // W transfer on this edge
    step();
    ocl_m2s.wvalid = 1'b0;
    if (addr == HELLO_WORLD_ADDR)
      m_scratch = data;
    if (addr == NONCE_SIZE_ADDR)
      m_nonce_size = data;
    if (addr == HASH_SEL_ADDR)
      m_hash_select = data[2:0];
    exp_pulses += $countones(expected_cmd(addr));
    exp_bresp++;
    // Pulses and settings visible one cycle after W
    sample();
    check_value("wready", 32'h0, {31'h0, ocl_s2m.wready});
    check_value("miner_cmd pulses", {27'h0, expected_cmd(addr)}, {27'h0, mon_pulses});
    if (expected_cmd(addr) != 5'b00000)
      check_value("miner_cmd.word", data, miner_cmd.word);
    check_value("nonce_size", m_nonce_size, nonce_size);
    check_value("hash_select", {29'h0, m_hash_select}, {29'h0, hash_select});
    n = 0;
    while (!ocl_s2m.bvalid)
    begin
      n++;
      if (n > TIMEOUT)
        timeout_error("bvalid");
      sample();
    end
    check_value("bresp", {30'h0, AXIL_RESP_OKAY}, {30'h0, ocl_s2m.bresp});
    // Host stalls the B channel
    delay = $urandom_range(3, 0);
    repeat (delay)
    begin
      step();
      sample();
      check_value("bvalid", 32'h1, {31'h0, ocl_s2m.bvalid});
      check_value("awready", 32'h0, {31'h0, ocl_s2m.awready});
    end
    step();
    ocl_m2s.bready = 1'b1;
    sample();
    check_value("bvalid", 32'h1, {31'h0, ocl_s2m.bvalid});
    step();
    ocl_m2s.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr);
    int          n;
    int          delay;
    logic [31:0] exp;
    step();
    ocl_m2s.arvalid = 1'b1;
    ocl_m2s.araddr  = addr;
    sample();
    n = 0;
    while (!ocl_s2m.arready)
    begin
      n++;
      if (n > TIMEOUT)
        timeout_error("arready");
      sample();
    end
    step();
    ocl_m2s.arvalid = 1'b0;
    exp = expected_read(addr);
    sample();
    n = 0;
    while (!ocl_s2m.rvalid)
    begin
      n++;
      if (n > TIMEOUT)
        timeout_error("rvalid");
      sample();
    end
    // First rvalid cycle
    check_value("hash_re", {31'h0, addr == HEAVYHASH_ADDR}, {31'h0, hash_re});
    check_value("rdata", exp, ocl_s2m.rdata);
    check_value("rresp", {30'h0, AXIL_RESP_OKAY}, {30'h0, ocl_s2m.rresp});
    if (addr == HEAVYHASH_ADDR)
      exp_hash_reads++;
    delay = $urandom_range(3, 0);
    repeat (delay)
    begin
      step();
      sample();
      check_value("rvalid", 32'h1, {31'h0, ocl_s2m.rvalid});
      check_value("rdata", exp, ocl_s2m.rdata);
      check_value("arready", 32'h0, {31'h0, ocl_s2m.arready});
      check_value("hash_re", 32'h0, {31'h0, hash_re});
    end
    step();
    ocl_m2s.rready = 1'b1;
    sample();
    check_value("rvalid", 32'h1, {31'h0, ocl_s2m.rvalid});
    step();
    ocl_m2s.rready = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Side-band stimulus
  // ------------------------------------------------------------
  task automatic new_miner_inputs();
    step();
    miner_status = miner_status_t'($urandom());
    nonce        = $urandom();
    heavyhash    = $urandom();
  endtask

  // Masked LED after everything has settled
  task automatic check_vled();
    repeat (4)
      step();
    sample();
    check_value("cl_sh_status_vled", {16'h0, m_scratch[15:0] & sh_cl_status_vdip},
                {16'h0, cl_sh_status_vled});
  endtask

  // New DIPs show up exactly three edges later
  task automatic change_dip();
    logic [15:0] old_dip;
    old_dip = sh_cl_status_vdip;
    step();
    sh_cl_status_vdip = 16'($urandom());
    step();
    step();
    sample();
    check_value("cl_sh_status_vled", {16'h0, m_scratch[15:0] & old_dip},
                {16'h0, cl_sh_status_vled});
    step();
    sample();
    check_value("cl_sh_status_vled", {16'h0, m_scratch[15:0] & sh_cl_status_vdip},
                {16'h0, cl_sh_status_vled});
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial
  begin
    void'($urandom(52));
    rst_main_n_sync   = 1'b0;
    ocl_m2s           = '0;
    sh_cl_status_vdip = 16'h0;
    miner_status      = '0;
    nonce             = 32'h0;
    heavyhash         = 32'h0;
    m_scratch         = 32'h0;
    m_nonce_size      = 32'h0;
    m_hash_select     = 3'h0;
    exp_pulses        = 0;
    exp_hash_reads    = 0;
    exp_bresp         = 0;
    seen_pulses       = 0;
    seen_hash_re      = 0;
    seen_bresp        = 0;

    repeat (2)
      @(posedge clk_main_a0);
    #1;
    rst_main_n_sync = 1'b1;

    // Reset values
    sample();
    check_value("awready", 32'h1, {31'h0, ocl_s2m.awready});
    check_value("wready", 32'h0, {31'h0, ocl_s2m.wready});
    check_value("arready", 32'h1, {31'h0, ocl_s2m.arready});
    check_value("bvalid", 32'h0, {31'h0, ocl_s2m.bvalid});
    check_value("rvalid", 32'h0, {31'h0, ocl_s2m.rvalid});
    check_value("miner_cmd pulses", 32'h0, {27'h0, mon_pulses});
    check_value("hash_re", 32'h0, {31'h0, hash_re});
    check_value("nonce_size", 32'h0, nonce_size);
    check_value("hash_select", 32'h0, {29'h0, hash_select});
    check_value("cl_sh_status_vled", 32'h0, {16'h0, cl_sh_status_vled});

    // Scratch comes out of reset at zero
    axil_read(HELLO_WORLD_ADDR);

    // Directed pass over the whole map
    axil_write(HELLO_WORLD_ADDR, $urandom());
    axil_read(HELLO_WORLD_ADDR);
    axil_read(VLED_ADDR);
    change_dip();
    for (int i = 2; i < 9; i++)
      axil_write(addr_table[i], $urandom());
    new_miner_inputs();
    for (int i = 9; i < 14; i++)
      axil_read(addr_table[i]);

    // Mixed random traffic
    for (int k = 0; k < N_OPS; k++)
    begin
      case ($urandom_range(3, 0))
        0: axil_write(addr_table[$urandom_range(13, 0)], $urandom());
        1:
        begin
          new_miner_inputs();
          axil_read(addr_table[$urandom_range(13, 0)]);
        end
        2: change_dip();
        default: check_vled();
      endcase
    end

    // Totals against the model
    repeat (3)
      step();
    check_value("B response count", exp_bresp, seen_bresp);
    check_value("miner_cmd pulse count", exp_pulses, seen_pulses);
    check_value("hash_re pulse count", exp_hash_reads, seen_hash_re);
    check_value("nonce_size", m_nonce_size, nonce_size);
    check_value("hash_select", {29'h0, m_hash_select}, {29'h0, hash_select});
    $display("TEST OK");
    $finish;
  end

endmodule
